// ==== verification/ex_pipe_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_pipe_tb import rv32i_model::*; ();

    localparam int clk_period = 100;
    localparam int n_chain    = 40;  // slots
    localparam int n_distance = 30;  // groups of up to 5 slots
    localparam int n_overlap  = 20;  // groups of 3
    localparam int n_zero     = 20;  // groups of 3
    localparam int n_upper    = 20;  // groups of 5
    localparam int n_random   = 400; // slots
    localparam int total_slots = n_chain + 5 * n_distance + 3 * n_overlap + 3 * n_zero
                                 + 5 * n_upper + n_random;
    localparam int watchdog_cycles = 10 + total_slots + 6 * 6 + 20;

    typedef struct packed {
        logic [4:0]  dest;
        logic [31:0] data;
        int          due;
    } retire_t;

    logic        clk;
    logic        rst_n;
    logic        issue_valid;
    logic [31:0] issue_instr;
    logic [31:0] issue_pc;
    logic        wb_valid;
    logic [4:0]  wb_dest;
    logic [31:0] wb_data;

    retire_t     expected [$];
    logic [31:0] pc = 32'h0000_1000;
    int          cycle = 0;
    int          checks = 0;
    int          errors = 0;
    int          mark_checks = 0;
    int          mark_errors = 0;

    ex_pipe_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .issue_pc    (issue_pc),
        .wb_valid    (wb_valid),
        .wb_dest     (wb_dest),
        .wb_data     (wb_data)
    );

    always #(clk_period / 2) clk = ~clk;

    // outputs are sampled on the falling edge, before the next drive
    task automatic check_retire();
        retire_t e;
        if (wb_valid) begin
            checks++;
            assert (expected.size() != 0) else begin
                $display("unexpected retirement of x%0d at cycle %0d", wb_dest, cycle);
                errors++;
            end
            if (expected.size() != 0) begin
                e = expected.pop_front();
                assert (wb_dest == e.dest) else begin
                    $display("[ERROR] wb_dest: got 0x%02h, expected 0x%02h", wb_dest, e.dest);
                    errors++;
                end
                assert (wb_data == e.data) else begin
                    $display("[ERROR] wb_data: got 0x%08h, expected 0x%08h", wb_data, e.data);
                    errors++;
                end
                assert (e.due == cycle) else begin
                    $display("x%0d retired at cycle %0d instead of cycle %0d",
                             e.dest, cycle, e.due);
                    errors++;
                end
            end
        end else if (expected.size() != 0) begin
            assert (expected[0].due > cycle) else begin
                e = expected.pop_front();
                $display("missing retirement of x%0d due at cycle %0d", e.dest, e.due);
                errors++;
            end
        end
    endtask

    // one falling-edge slot, the model runs at issue time
    task automatic step(input logic v, input logic [31:0] instr);
        logic [31:0] result;
        retire_t     e;
        @(negedge clk);
        cycle++;
        check_retire();
        issue_valid = v;
        issue_instr = instr;
        issue_pc    = pc;
        if (v) begin
            if (execute(instr, pc, result)) begin
                e.dest = instr[11:7];
                e.data = result;
                e.due  = cycle + 3; // fixed latency
                expected.push_back(e);
            end
            pc += 32'd4;
        end
    endtask

    task automatic finish_test(input string name);
        while (expected.size() != 0) begin
            step(1'b0, 32'h0);
        end
        repeat (3) step(1'b0, 32'h0); // catches stray retirements
        $display("test %s done, %0d checks, %0d errors", name,
                 checks - mark_checks, errors - mark_errors);
        mark_checks = checks;
        mark_errors = errors;
    endtask

    task automatic run_chain(input int n);
        logic [4:0] prev;
        logic [4:0] rd;
        prev = pick_dest();
        repeat (n) begin
            rd = pick_dest();
            step(1'b1, make_instr($urandom_range(4, 3), rd, prev,
                                  $urandom_range(1, 0) ? prev : pick_reg()));
            prev = rd;
        end
    endtask

    task automatic run_distance(input int n);
        logic [4:0] rd;
        logic [4:0] other;
        int         gap;
        repeat (n) begin
            rd    = pick_dest();
            other = (rd % 7) + 1;
            gap   = $urandom_range(3, 1); // consumer at distance 2..4
            step(1'b1, make_instr(4, rd, pick_reg(), pick_reg()));
            repeat (gap) step(1'b1, make_instr(3, other, pick_reg(), pick_reg()));
            step(1'b1, make_instr(4, pick_dest(), rd, rd));
        end
    endtask

    task automatic run_overlap(input int n);
        logic [4:0] rd;
        repeat (n) begin
            rd = pick_dest();
            step(1'b1, make_instr(3, rd, pick_reg(), pick_reg()));
            step(1'b1, make_instr(3, rd, pick_reg(), pick_reg()));
            step(1'b1, make_instr(4, pick_dest(), rd, rd)); // younger write wins
        end
    endtask

    task automatic run_zero(input int n);
        repeat (n) begin
            step(1'b1, make_instr($urandom_range(4, 0), 5'd0, pick_reg(), pick_reg()));
            step(1'b1, make_instr(4, pick_dest(), 5'd0, 5'd0));
            step(1'b1, make_instr(3, pick_dest(), 5'd0, pick_reg()));
        end
    endtask

    task automatic run_upper(input int n);
        logic [4:0] rd;
        repeat (n) begin
            rd = pick_dest();
            step(1'b1, make_instr(3, rd, pick_reg(), pick_reg()));
            // rs1 field matches a live writer but must be ignored
            step(1'b1, make_instr($urandom_range(2, 0), pick_dest(), rd, rd));
            step(1'b1, make_instr($urandom_range(7, 5), pick_dest(), rd, rd));
            step(1'b1, make_instr($urandom_range(7, 5), pick_dest(), rd, rd));
            step(1'b1, make_instr(4, pick_dest(), rd, rd));
        end
    endtask

    task automatic run_random(input int n);
        repeat (n) begin
            if ($urandom_range(3, 0) == 0)
                step(1'b0, $urandom); // idle slot, junk on the bus
            else
                step(1'b1, make_instr($urandom_range(7, 0), pick_reg(), pick_reg(), pick_reg()));
        end
    endtask

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog expired after %0d cycles", watchdog_cycles);
        $display("Errors found");
        $finish;
    end

    initial begin
        void'($urandom(63391));
        clk         = 1'b0;
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        issue_instr = '0;
        issue_pc    = '0;
        reset_model();
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        run_chain(n_chain);
        finish_test("back_to_back");
        run_distance(n_distance);
        finish_test("distance");
        run_overlap(n_overlap);
        finish_test("mem_over_wb");
        run_zero(n_zero);
        finish_test("x0");
        run_upper(n_upper);
        finish_test("upper_and_no_write");
        run_random(n_random);
        finish_test("random_gaps");

        $display("6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/rv32i_model.sv ====
`default_nettype none

package rv32i_model;

    localparam logic [6:0] opc_lui   = 7'b0110111;
    localparam logic [6:0] opc_auipc = 7'b0010111;
    localparam logic [6:0] opc_jal   = 7'b1101111;
    localparam logic [6:0] opc_br    = 7'b1100011;
    localparam logic [6:0] opc_load  = 7'b0000011;
    localparam logic [6:0] opc_store = 7'b0100011;
    localparam logic [6:0] opc_imm   = 7'b0010011;
    localparam logic [6:0] opc_reg   = 7'b0110011;

    logic [31:0] xreg [0:31]; // architectural register state

    function automatic void reset_model();
        for (int i = 0; i < 32; i++) begin
            xreg[i] = '0;
        end
    endfunction

    // x0..x7 only, keeps hazards frequent
    function automatic logic [4:0] pick_reg();
        return $urandom_range(7, 0);
    endfunction

    function automatic logic [4:0] pick_dest();
        return $urandom_range(7, 1);
    endfunction

    // kind: 0 lui, 1 auipc, 2 jal, 3 imm, 4 reg, 5 br, 6 store, 7 load
    function automatic logic [31:0] make_instr(input int kind, input logic [4:0] rd,
                                               input logic [4:0] rs1, input logic [4:0] rs2);
        logic [31:0] r;
        logic [2:0]  f3;
        r  = $urandom;
        f3 = r[14:12];
        if (f3 == 3'b010 || f3 == 3'b011)
            f3 = f3 + 3'd2; // no slt/sltu
        case (kind)
            0: return {r[31:20], rs1, r[14:12], rd, opc_lui};
            1: return {r[31:20], rs1, r[14:12], rd, opc_auipc};
            2: return {r[31:20], rs1, r[14:12], rd, opc_jal};
            3: begin
                if (f3 == 3'b001)
                    return {7'b0, r[24:20], rs1, f3, rd, opc_imm};
                else if (f3 == 3'b101)
                    return {1'b0, r[30], 5'b0, r[24:20], rs1, f3, rd, opc_imm};
                else
                    return {r[31:20], rs1, f3, rd, opc_imm};
            end
            4: begin
                return {1'b0, (f3 == 3'b000 || f3 == 3'b101) ? r[30] : 1'b0, 5'b0,
                        rs2, rs1, f3, rd, opc_reg};
            end
            5: return {r[31:25], rs2, rs1, r[14:12], r[11:7], opc_br};
            6: return {r[31:25], rs2, rs1, 3'b010, r[11:7], opc_store};
            default: return {r[31:20], rs1, 3'b010, rd, opc_load};
        endcase
    endfunction

    // sequential ISA semantics, returns 1 when a nonzero rd is written
    function automatic bit execute(input logic [31:0] instr, input logic [31:0] pc,
                                   output logic [31:0] result);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_u;
        logic [2:0]  f3;
        a      = xreg[instr[19:15]];
        b      = xreg[instr[24:20]];
        imm_u  = {instr[31:12], 12'h000};
        f3     = instr[14:12];
        result = '0;
        case (instr[6:0])
            opc_lui:   result = imm_u;
            opc_auipc: result = pc + imm_u;
            opc_jal:   result = pc + 32'd4; // link only
            opc_imm, opc_reg: begin
                if (instr[6:0] == opc_imm)
                    b = {{20{instr[31]}}, instr[31:20]};
                case (f3)
                    3'b000:  result = (instr[6:0] == opc_reg && instr[30]) ? a - b : a + b;
                    3'b001:  result = a << b[4:0];
                    3'b100:  result = a ^ b;
                    3'b101: begin
                        if (instr[30])
                            result = $signed(a) >>> b[4:0]; // sign fill
                        else
                            result = a >> b[4:0];
                    end
                    3'b110:  result = a | b;
                    3'b111:  result = a & b;
                    default: return 1'b0;
                endcase
            end
            default: return 1'b0; // br, store, load write nothing
        endcase
        if (instr[11:7] == 5'd0)
            return 1'b0;
        xreg[instr[11:7]] = result;
        return 1'b1;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/ex_pipe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_pipe_top import rv32i_types::*; (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic issue_valid,
    input  rv32i_word issue_instr,
    input  rv32i_word issue_pc,
    output logic      wb_valid,
    output rv32i_reg  wb_dest,
    output rv32i_word wb_data
);

    rv32i_control_word cw_ex;
    rv32i_control_word cw_mem;
    rv32i_control_word cw_wb;
    rv32i_word         rs1_ex;
    rv32i_word         rs2_ex;
    rv32i_word         imm_ex;
    logic              rf_we;
    rv32i_reg          rf_waddr;
    rv32i_word         rf_wdata;

    fwd_bus_if fwd ();

    id_stage u_id (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .issue_pc    (issue_pc),
        .we          (rf_we),
        .waddr       (rf_waddr),
        .wdata       (rf_wdata),
        .cw_ex       (cw_ex),
        .rs1_ex      (rs1_ex),
        .rs2_ex      (rs2_ex),
        .imm_ex      (imm_ex)
    );

    forwarding_unit u_fwd (
        .cw_ex  (cw_ex),
        .cw_mem (cw_mem),
        .cw_wb  (cw_wb),
        .fwd    (fwd.fwd_src)
    );

    // stage results land directly on the forwarding bus
    execute_stage u_ex (
        .clk        (clk),
        .rst_n      (rst_n),
        .cw_ex      (cw_ex),
        .rs1_ex     (rs1_ex),
        .rs2_ex     (rs2_ex),
        .imm_ex     (imm_ex),
        .fwd        (fwd.fwd_dst),
        .cw_mem     (cw_mem),
        .mem_result (fwd.mem_result)
    );

    writeback_stage u_wb (
        .clk        (clk),
        .rst_n      (rst_n),
        .cw_mem     (cw_mem),
        .mem_result (fwd.mem_result),
        .cw_wb      (cw_wb),
        .wb_result  (fwd.wb_result),
        .we         (rf_we),
        .waddr      (rf_waddr),
        .wdata      (rf_wdata),
        .wb_valid   (wb_valid),
        .wb_dest    (wb_dest),
        .wb_data    (wb_data)
    );

endmodule

`default_nettype wire

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage import rv32i_types::*; (
    input  wire logic         clk,
    input  wire logic         rst_n,
    input  rv32i_control_word cw_ex,
    input  rv32i_word         rs1_ex,
    input  rv32i_word         rs2_ex,
    input  rv32i_word         imm_ex,
    fwd_bus_if.fwd_dst        fwd,
    output rv32i_control_word cw_mem,
    output rv32i_word         mem_result
);

    rv32i_word  op_a;
    rv32i_word  op_b;
    rv32i_word  alu_out;
    logic [4:0] shamt;

    // operand a
    always_comb begin
        if (fwd.forward_a[1])
            op_a = fwd.forward_a[0] ? fwd.wb_result : fwd.mem_result;
        else if (alumux1_sel_t'(fwd.forward_a[0]) == pc_out)
            op_a = cw_ex.pc;
        else if (rv32i_opcode'(cw_ex.instr[6:0]) == op_lui)
            op_a = '0; // lui is zero plus u-immediate
        else
            op_a = rs1_ex;
    end

    // operand b, all immediate selects come in already formatted as imm_ex
    always_comb begin
        if (fwd.forward_b[3]) begin
            op_b = fwd.forward_b[0] ? fwd.wb_result : fwd.mem_result;
        end else begin
            case (alumux2_sel_t'(fwd.forward_b[2:0]))
                rs2_out:    op_b = rs2_ex;
                four_const: op_b = 32'd4;
                default:    op_b = imm_ex;
            endcase
        end
    end

    assign shamt = op_b[4:0];

    always_comb begin
        case (cw_ex.aluop)
            add:     alu_out = op_a + op_b;
            sll:     alu_out = op_a << shamt;
            sra:     alu_out = rv32i_word'($signed(op_a) >>> shamt);
            sub:     alu_out = op_a - op_b;
            axor:    alu_out = op_a ^ op_b;
            srl:     alu_out = op_a >> shamt;
            aor:     alu_out = op_a | op_b;
            default: alu_out = op_a & op_b;
        endcase
    end

    // EX/MEM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            cw_mem <= '0;
        else
            cw_mem <= cw_ex;
    end

    always_ff @(posedge clk) begin
        mem_result <= alu_out;
    end

endmodule

`default_nettype wire

// ==== verilog/forwarding_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module forwarding_unit import rv32i_types::*; (
    input  rv32i_control_word cw_ex,
    input  rv32i_control_word cw_mem,
    input  rv32i_control_word cw_wb,
    fwd_bus_if.fwd_src        fwd
);

    rv32i_opcode opcode_ex;
    rv32i_reg    rs1_ex;
    rv32i_reg    rs2_ex;
    logic        mem_writes;
    logic        wb_writes;
    logic        uses_rs1;
    logic        uses_rs2;
    fwd_a_t      fwd_a;
    fwd_b_t      fwd_b;

    assign opcode_ex = rv32i_opcode'(cw_ex.instr[6:0]);
    assign rs1_ex    = cw_ex.instr[19:15];
    assign rs2_ex    = cw_ex.instr[24:20];

    // a stage only forwards a live nonzero destination
    assign mem_writes = cw_mem.valid && cw_mem.load_regfile && (cw_mem.dest != '0);
    assign wb_writes  = cw_wb.valid && cw_wb.load_regfile && (cw_wb.dest != '0);

    // lui/auipc/jal take pc or immediate, rs1 field is not a register there
    assign uses_rs1 = !(opcode_ex inside {op_lui, op_auipc, op_jal});
    assign uses_rs2 = opcode_ex inside {op_reg, op_store, op_br};

    always_comb begin
        if (uses_rs1 && mem_writes && cw_mem.dest == rs1_ex)
            fwd_a = 2'b10;
        else if (uses_rs1 && wb_writes && cw_wb.dest == rs1_ex)
            fwd_a = 2'b11;
        else
            fwd_a = {1'b0, cw_ex.alu_muxsel1};

        // mem is younger, so it wins over wb
        if (uses_rs2 && mem_writes && cw_mem.dest == rs2_ex)
            fwd_b = 4'b1000;
        else if (uses_rs2 && wb_writes && cw_wb.dest == rs2_ex)
            fwd_b = 4'b1001;
        else
            fwd_b = {1'b0, cw_ex.alu_muxsel2};
    end

    assign fwd.forward_a = fwd_a;
    assign fwd.forward_b = fwd_b;

endmodule

`default_nettype wire

// ==== verilog/fwd_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface fwd_bus_if import rv32i_types::*; ();

    fwd_a_t    forward_a;
    fwd_b_t    forward_b;
    rv32i_word mem_result; // EX/MEM result
    rv32i_word wb_result;  // MEM/WB result

    modport fwd_src (
        output forward_a,
        output forward_b
    );

    modport fwd_dst (
        input forward_a,
        input forward_b,
        input mem_result,
        input wb_result
    );

endinterface

`default_nettype wire

// ==== verilog/id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_stage import rv32i_types::*; (
    input  wire logic         clk,
    input  wire logic         rst_n,
    input  wire logic         issue_valid,
    input  rv32i_word         issue_instr,
    input  rv32i_word         issue_pc,
    input  wire logic         we,
    input  rv32i_reg          waddr,
    input  rv32i_word         wdata,
    output rv32i_control_word cw_ex,
    output rv32i_word         rs1_ex,
    output rv32i_word         rs2_ex,
    output rv32i_word         imm_ex
);

    rv32i_opcode       opcode;
    logic [2:0]        funct3;
    logic              writes_rd;
    alu_ops            alu_dec;
    rv32i_word         imm;
    rv32i_word         rs1_rd;
    rv32i_word         rs2_rd;
    rv32i_control_word cw_dec;

    assign opcode = rv32i_opcode'(issue_instr[6:0]);
    assign funct3 = issue_instr[14:12];

    regfile u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .we     (we),
        .waddr  (waddr),
        .wdata  (wdata),
        .raddr1 (issue_instr[19:15]),
        .raddr2 (issue_instr[24:20]),
        .rdata1 (rs1_rd),
        .rdata2 (rs2_rd)
    );

    // bit 30 picks sub only for register ops, sra for both
    always_comb begin
        case (funct3)
            3'b000:  alu_dec = (opcode == op_reg && issue_instr[30]) ? sub : add;
            3'b001:  alu_dec = sll;
            3'b100:  alu_dec = axor;
            3'b101:  alu_dec = issue_instr[30] ? sra : srl;
            3'b110:  alu_dec = aor;
            default: alu_dec = aand;
        endcase
    end

    always_comb begin
        cw_dec             = '0;
        cw_dec.instr       = issue_instr;
        cw_dec.pc          = issue_pc;
        cw_dec.dest        = issue_instr[11:7];
        cw_dec.aluop       = add;
        cw_dec.alu_muxsel1 = rs1_out;
        cw_dec.alu_muxsel2 = i_imm;
        writes_rd          = 1'b0;
        imm = {{21{issue_instr[31]}}, issue_instr[30:20]}; // i-type
        case (opcode)
            op_lui, op_auipc: begin
                imm                = {issue_instr[31:12], 12'h000};
                cw_dec.alu_muxsel1 = (opcode == op_auipc) ? pc_out : rs1_out;
                cw_dec.alu_muxsel2 = u_imm;
                cw_dec.valid       = 1'b1;
                writes_rd          = 1'b1;
            end
            op_jal: begin // link only, no redirect
                imm = {{12{issue_instr[31]}}, issue_instr[19:12], issue_instr[20],
                       issue_instr[30:21], 1'b0};
                cw_dec.alu_muxsel1 = pc_out;
                cw_dec.alu_muxsel2 = four_const;
                cw_dec.valid       = 1'b1;
                writes_rd          = 1'b1;
            end
            op_imm, op_reg: begin
                // slt/sltu have no alu op and go down as bubbles
                cw_dec.valid       = (funct3 != 3'b010) && (funct3 != 3'b011);
                cw_dec.aluop       = alu_dec;
                cw_dec.alu_muxsel2 = (opcode == op_reg) ? rs2_out : i_imm;
                writes_rd          = 1'b1;
            end
            op_br: begin
                imm = {{20{issue_instr[31]}}, issue_instr[7], issue_instr[30:25],
                       issue_instr[11:8], 1'b0};
                cw_dec.alu_muxsel2 = b_imm;
                cw_dec.valid       = 1'b1;
            end
            op_store: begin
                imm = {{21{issue_instr[31]}}, issue_instr[30:25], issue_instr[11:7]};
                cw_dec.alu_muxsel2 = s_imm;
                cw_dec.valid       = 1'b1;
            end
            default: ; // loads and the rest stay bubbles
        endcase
        cw_dec.load_regfile = cw_dec.valid && writes_rd && (cw_dec.dest != '0);
    end

    // ID/EX
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            cw_ex <= '0;
        else
            cw_ex <= issue_valid ? cw_dec : '0;
    end

    always_ff @(posedge clk) begin
        rs1_ex <= rs1_rd;
        rs2_ex <= rs2_rd;
        imm_ex <= imm;
    end

endmodule

`default_nettype wire

// ==== verilog/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile import rv32i_types::*; (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic we,
    input  rv32i_reg  waddr,
    input  rv32i_word wdata,
    input  rv32i_reg  raddr1,
    input  rv32i_reg  raddr2,
    output rv32i_word rdata1,
    output rv32i_word rdata2
);

    rv32i_word regs [1:31]; // x0 is not stored

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads zero, a same-cycle write is passed straight through
    function automatic rv32i_word read_port(input rv32i_reg addr);
        if (addr == '0)
            return '0;
        else if (we && addr == waddr)
            return wdata;
        else
            return regs[addr];
    endfunction

    always_comb begin
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
    end

endmodule

`default_nettype wire

// ==== verilog/rv32i_types.sv ====
`default_nettype none

package rv32i_types;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  rv32i_reg;

    // RV32I major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_csr   = 7'b1110011
    } rv32i_opcode;

    typedef enum logic [2:0] {
        add, sll, sra, sub, axor, srl, aor, aand
    } alu_ops;

    typedef enum logic {
        rs1_out = 1'b0,
        pc_out  = 1'b1
    } alumux1_sel_t;

    typedef enum logic [2:0] {
        i_imm      = 3'd0,
        u_imm      = 3'd1,
        b_imm      = 3'd2,
        s_imm      = 3'd3,
        j_imm      = 3'd4,
        rs2_out    = 3'd5,
        four_const = 3'd6
    } alumux2_sel_t;

    typedef struct packed {
        rv32i_word    instr;
        rv32i_word    pc;
        rv32i_reg     dest;
        logic         load_regfile;
        alu_ops       aluop;
        alumux1_sel_t alu_muxsel1;
        alumux2_sel_t alu_muxsel2;
        logic         valid;
    } rv32i_control_word;

    // 1x = forwarded result (10 mem, 11 wb), else {0, alu_muxsel1}
    typedef logic [1:0] fwd_a_t;
    // 1000 mem, 1001 wb, else {0, alu_muxsel2}
    typedef logic [3:0] fwd_b_t;

endpackage

`default_nettype wire

// ==== verilog/writeback_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback_stage import rv32i_types::*; (
    input  wire logic         clk,
    input  wire logic         rst_n,
    input  rv32i_control_word cw_mem,
    input  rv32i_word         mem_result,
    output rv32i_control_word cw_wb,
    output rv32i_word         wb_result,
    output logic              we,
    output rv32i_reg          waddr,
    output rv32i_word         wdata,
    output logic              wb_valid,
    output rv32i_reg          wb_dest,
    output rv32i_word         wb_data
);

    logic retire;

    // MEM/WB, no data memory so the result goes straight through
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            cw_wb <= '0;
        else
            cw_wb <= cw_mem;
    end

    always_ff @(posedge clk) begin
        wb_result <= mem_result;
    end

    assign retire = cw_wb.valid && cw_wb.load_regfile; // stores/branches never retire

    // regfile write, lands on the next edge
    assign we    = retire;
    assign waddr = cw_wb.dest;
    assign wdata = wb_result;

    assign wb_valid = retire;
    assign wb_dest  = cw_wb.dest;
    assign wb_data  = wb_result;

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/rv32i_types.sv
verilog/fwd_bus_if.sv
verilog/regfile.sv
verilog/id_stage.sv
verilog/forwarding_unit.sv
verilog/execute_stage.sv
verilog/writeback_stage.sv
verilog/ex_pipe_top.sv
verification/rv32i_model.sv
verification/ex_pipe_tb.sv
